// File: src/fnd_pkg.sv
package fnd_pkg;

    ////////////////////////////////////////////////////////////
    // display geometry
    ////////////////////////////////////////////////////////////

    localparam int DIGITS = 4;                  // four-digit common-anode module

    // one hex digit as shown on a single position
    typedef logic [3:0] nibble_t;

    // digit select lines, active low, bit 0 is the rightmost digit
    typedef logic [DIGITS-1:0] com_t;

    // segment lines, active low
    // bit 7 is segment a, down to bit 1 for g, bit 0 is the decimal point
    typedef logic [7:0] seg_t;

    // the sixteen displayed bits, digit 0 sits in the low nibble
    typedef nibble_t [DIGITS-1:0] disp_word_t;

    // display bus as it leaves the chip
    typedef struct packed {
        com_t com;                              // which digit is lit
        seg_t seg;                              // what the lit digit shows
    } fnd_t;

    localparam com_t COM_RESET = 4'b1110;       // scan starts on the rightmost digit

    ////////////////////////////////////////////////////////////
    // segment patterns, a..g then dp, zero lights the segment
    ////////////////////////////////////////////////////////////

    localparam seg_t SEG_0 = 8'b0000_0011;
    localparam seg_t SEG_1 = 8'b1001_1111;
    localparam seg_t SEG_2 = 8'b0010_0101;
    localparam seg_t SEG_3 = 8'b0000_1101;
    localparam seg_t SEG_4 = 8'b1001_1001;
    localparam seg_t SEG_5 = 8'b0100_1001;
    localparam seg_t SEG_6 = 8'b0100_0001;
    localparam seg_t SEG_7 = 8'b0001_1011;
    localparam seg_t SEG_8 = 8'b0000_0001;
    localparam seg_t SEG_9 = 8'b0001_1001;
    localparam seg_t SEG_A = 8'b0001_0001;
    localparam seg_t SEG_B = 8'b1100_0001;     // lower case b shape
    localparam seg_t SEG_C = 8'b0110_0011;     // full C, top bar lit
    localparam seg_t SEG_D = 8'b1000_0101;     // lower case d shape
    localparam seg_t SEG_E = 8'b0110_0001;
    localparam seg_t SEG_F = 8'b0111_0001;

endpackage

// File: src/scan_tick_gen.sv
`timescale 1ns/1ps

module scan_tick_gen #(
    parameter int DIV_W = 17                    // tick period is 2**DIV_W clocks
) (
    input  logic clk,
    input  logic reset_p,
    output logic tick
);

    logic [DIV_W-1:0] div_cnt;                  // free-running divider
    logic             div_cur;                  // top bit, sampled once
    logic             div_old;                  // top bit, one cycle older

    ////////////////////////////////////////////////////////////
    // clock divider
    ////////////////////////////////////////////////////////////

    // holds the edge count modulo 2**DIV_W
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // rising edge detector on the divider top bit
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            div_cur <= 1'b0;
            div_old <= 1'b0;
        end else begin
            div_cur <= div_cnt[DIV_W-1];
            div_old <= div_cur;                 // one more stage for the compare
        end
    end

    // high for a single cycle per divider period
    assign tick = div_cur & ~div_old;

    // a held tick would skip digits in the scanner
    a_tick_one_cycle: assert property (
        @(posedge clk) disable iff (reset_p)
        tick |=> !tick
    ) else $error("scan tick held high for more than one cycle");

endmodule

// File: src/digit_scanner.sv
`timescale 1ns/1ps

module digit_scanner (
    input  logic                clk,
    input  logic                reset_p,
    input  logic                tick,
    input  fnd_pkg::disp_word_t word,
    output fnd_pkg::com_t       com,
    output fnd_pkg::nibble_t    digit
);

    import fnd_pkg::*;

    logic    com_legal;                         // exactly one line low
    com_t    com_next;                          // ring value after a step
    nibble_t digit_next;                        // nibble picked by the current com

    // counts the low lines of a select value
    function automatic logic one_low(input com_t sel);
        int zeros;
        zeros = 0;
        for (int i = 0; i < DIGITS; i++) begin
            if (!sel[i]) begin
                zeros++;
            end
        end
        return (zeros == 1);
    endfunction

    ////////////////////////////////////////////////////////////
    // digit select ring
    ////////////////////////////////////////////////////////////

    assign com_legal = one_low(com);

    // the low bit walks from digit 0 toward the leftmost digit
    always_comb begin
        if (com_legal) begin
            com_next = {com[DIGITS-2:0], com[DIGITS-1]};
        end else begin
            com_next = COM_RESET;               // recover from a corrupted ring
        end
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            com <= COM_RESET;
        end else if (tick || !com_legal) begin
            com <= com_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // nibble selector
    ////////////////////////////////////////////////////////////

    // walk down so the lowest active line wins
    always_comb begin
        digit_next = '0;
        for (int i = DIGITS - 1; i >= 0; i--) begin
            if (!com[i]) begin
                digit_next = word[i];
            end
        end
    end

    // uses com and word from before the edge
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            digit <= '0;
        end else begin
            digit <= digit_next;
        end
    end

    // two lit digits would ghost on the display
    a_com_one_low: assert property (
        @(posedge clk) disable iff (reset_p)
        $onehot(~com)
    ) else $error("digit select has %b, not a single low line", com);

endmodule

// File: src/seg7_decoder.sv
`timescale 1ns/1ps

module seg7_decoder (
    input  fnd_pkg::nibble_t digit,
    output fnd_pkg::seg_t    seg
);

    import fnd_pkg::*;

    ////////////////////////////////////////////////////////////
    // hex digit to segment pattern, active low
    ////////////////////////////////////////////////////////////

    // decimal point is never lit, so bit 0 is always 1
    always_comb begin
        unique case (digit)
            4'h0: seg = SEG_0;
            4'h1: seg = SEG_1;
            4'h2: seg = SEG_2;
            4'h3: seg = SEG_3;
            4'h4: seg = SEG_4;
            4'h5: seg = SEG_5;
            4'h6: seg = SEG_6;
            4'h7: seg = SEG_7;
            4'h8: seg = SEG_8;
            4'h9: seg = SEG_9;
            4'ha: seg = SEG_A;
            4'hb: seg = SEG_B;                  // b and d are lower case so they differ from 8 and 0
            4'hc: seg = SEG_C;
            4'hd: seg = SEG_D;
            4'he: seg = SEG_E;
            4'hf: seg = SEG_F;
        endcase
    end

endmodule

// File: src/fnd_counter_top.sv
`timescale 1ns/1ps

module fnd_counter_top #(
    parameter int COUNT_W = 32,                 // at least the sixteen displayed bits
    parameter int DIV_W   = 17                  // scan divider width
) (
    input  logic                clk,
    input  logic                reset_p,
    output fnd_pkg::disp_word_t count,
    output fnd_pkg::fnd_t       fnd
);

    import fnd_pkg::*;

    logic [COUNT_W-1:0] count_q;                // free-running counter
    logic               scan_tick;              // one cycle per scan step
    com_t               scan_com;
    nibble_t            scan_digit;             // value of the lit digit
    seg_t               seg_pat;

    ////////////////////////////////////////////////////////////
    // free-running counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;          // wraps at 2**COUNT_W
        end
    end

    // only the slow upper bits are visible to the eye
    assign count = count_q[COUNT_W-1 -: $bits(disp_word_t)];

    ////////////////////////////////////////////////////////////
    // display scan path
    ////////////////////////////////////////////////////////////

    scan_tick_gen #(
        .DIV_W   (DIV_W)
    ) u_tick (
        .clk     (clk),
        .reset_p (reset_p),
        .tick    (scan_tick)
    );

    digit_scanner u_scan (
        .clk     (clk),
        .reset_p (reset_p),
        .tick    (scan_tick),
        .word    (count),
        .com     (scan_com),
        .digit   (scan_digit)
    );

    seg7_decoder u_dec (
        .digit   (scan_digit),
        .seg     (seg_pat)
    );

    assign fnd = '{com: scan_com, seg: seg_pat};

endmodule

// File: verif/fnd_counter_tb.sv
`timescale 1ns/1ps

module fnd_counter_tb;

    import fnd_pkg::*;

    localparam int COUNT_W = 18;                // count shows the edge number divided by 4
    localparam int DIV_W   = 3;                 // scan step every 8 clocks
    localparam int ROWS    = 58;                // rows in the vector file
    localparam int FIELDS  = 5;                 // index, reset, count, com, seg
    localparam int PERIOD  = 20;

    logic       clk;
    logic       reset_p;
    disp_word_t count;
    fnd_t       fnd;

    // flat copy of the vector file, FIELDS words per row
    logic [15:0] vec_mem [0:ROWS*FIELDS-1];

    fnd_counter_top #(
        .COUNT_W (COUNT_W),
        .DIV_W   (DIV_W)
    ) dut0 (
        .clk     (clk),
        .reset_p (reset_p),
        .count   (count),
        .fnd     (fnd)
    );

    always #(PERIOD/2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // error reporting
    ////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(
        input string       name,
        input logic [15:0] expected,
        input logic [15:0] actual
    );
        stop_on_error($sformatf("Fail %s expected %h got %h", name, expected, actual));
    endtask

    ////////////////////////////////////////////////////////////
    // output compare for one vector row
    ////////////////////////////////////////////////////////////

    task automatic check_row(input int row);
        int          base;
        logic [15:0] exp_count;
        logic [3:0]  exp_com;
        logic [7:0]  exp_seg;
        base      = row * FIELDS;
        exp_count = vec_mem[base + 2];
        exp_com   = vec_mem[base + 3][3:0];     // active low, one line down
        exp_seg   = vec_mem[base + 4][7:0];
        assert (count == exp_count) else begin
            report_mismatch("count", exp_count, count);
        end
        assert (fnd.com == exp_com) else begin
            report_mismatch("fnd.com", 16'(exp_com), 16'(fnd.com));
        end
        assert (fnd.seg == exp_seg) else begin
            report_mismatch("fnd.seg", 16'(exp_seg), 16'(fnd.seg));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus and checking
    ////////////////////////////////////////////////////////////

    initial begin
        int base;
        clk     = 1'b0;
        reset_p = 1'b1;                         // held until row 0 is applied
        $readmemh("verif/fnd_vectors.txt", vec_mem);

        for (int row = 0; row < ROWS; row++) begin
            base = row * FIELDS;
            // a shifted or missing row would throw every later compare off
            assert (vec_mem[base] == 16'(row)) else begin
                stop_on_error($sformatf("vector row %0d carries the wrong index %0h",
                                        row, vec_mem[base]));
            end
            reset_p = vec_mem[base + 1][0];     // applied on the falling edge
            @(posedge clk);
            @(negedge clk);                     // outputs have settled here
            check_row(row);
        end

        $display("All checks passed");
        $finish;
    end

    // watchdog, a few spare cycles past the last row
    initial begin
        #((ROWS + 10) * PERIOD);
        stop_on_error("watchdog expired before all vector rows were checked");
    end

endmodule

// File: verif/fnd_vectors.txt
// columns in hex: row index, reset level, expected count, expected com, expected seg
// expected values hold on the falling edge after the rising edge of that row's cycle
00 1 0000 e 03
01 1 0000 e 03
02 0 0000 e 03
03 0 0000 e 03
04 0 0000 e 03
05 0 0001 e 03
06 0 0001 e 9f
07 0 0001 d 9f
08 0 0001 d 03
09 0 0002 d 03
0a 0 0002 d 03
0b 0 0002 d 03
0c 0 0002 d 03
0d 0 0003 d 03
0e 0 0003 d 03
0f 0 0003 b 03
10 0 0003 b 03
11 0 0004 b 03
12 0 0004 b 03
13 0 0004 b 03
14 0 0004 b 03
15 0 0005 b 03
16 0 0005 b 03
17 0 0005 7 03
18 0 0005 7 03
19 0 0006 7 03
1a 0 0006 7 03
1b 0 0006 7 03
1c 0 0006 7 03
1d 0 0007 7 03
1e 0 0007 7 03
1f 0 0007 e 03
20 0 0007 e 1b
21 0 0008 e 1b
22 0 0008 e 01
23 0 0008 e 01
24 0 0008 e 01
25 0 0009 e 01
26 0 0009 e 19
27 0 0009 d 19
28 0 0009 d 03
29 0 000a d 03
2a 1 0000 e 03
2b 0 0000 e 03
2c 0 0000 e 03
2d 0 0000 e 03
2e 0 0001 e 03
2f 0 0001 e 9f
30 0 0001 d 9f
31 0 0001 d 03
32 0 0002 d 03
33 0 0002 d 03
34 0 0002 d 03
35 0 0002 d 03
36 0 0003 d 03
37 0 0003 d 03
38 0 0003 b 03
39 0 0003 b 03

// File: fnd_counter_top.f
src/fnd_pkg.sv
src/scan_tick_gen.sv
src/digit_scanner.sv
src/seg7_decoder.sv
src/fnd_counter_top.sv
verif/fnd_counter_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the display counter testbench with verilator and runs it
# the run counts as passed only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module fnd_counter_tb \
    -f fnd_counter_top.f \
    -o fnd_counter_sim || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/fnd_counter_sim 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qx "All checks passed" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
